/* files.f */
+incdir+bench
hw/core_pkg.sv
hw/bus_pkg.sv
hw/ctrl_unit.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/csr_unit.sv
hw/commit_unit.sv
hw/rv_core.sv
bench/tb_rv_core.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_rv_core
FILELIST    ?= files.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
PASS_MSG    ?= Testbench passed
VFLAGS      ?= --timing --assert --timescale 1ns/1ps
BUILD_FLAGS ?= --binary -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator status is not trusted, the log decides
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not report a pass"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_program.svh */
typedef enum logic [2:0] {
	PORT_NONE,
	PORT_LOAD,
	PORT_LOAD_MODEL, // Expected data is the model word at the load address
	PORT_STORE,
	PORT_DMA
} port_e;

// A row holds the instruction with its pc, the expected rd write, rd and rd data,
// and the expected data port, address and store data
typedef struct packed {
	logic [31:0] inst;
	logic [31:0] pc;
	logic        rd_we;
	logic [4:0]  rd;
	logic [31:0] rd_data;
	port_e       port;
	logic [31:0] addr;
	logic [31:0] wdata;
} row_t;

row_t rows [$];

////////////////////////////////////////
// Instruction encoders
////////////////////////////////////////

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, OP_R};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_B};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
	input logic [6:0] op);
	return {imm, rd, op};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// A register write is expected whenever rd is not x0
task automatic add_row(input logic [31:0] inst, input logic [31:0] pc, input logic [4:0] rd,
	input logic [31:0] data, input port_e port, input logic [31:0] addr,
	input logic [31:0] wdata);
	row_t r;
	r.inst    = inst;
	r.pc      = pc;
	r.rd_we   = (rd != 5'd0);
	r.rd      = rd;
	r.rd_data = data;
	r.port    = port;
	r.addr    = addr;
	r.wdata   = wdata;
	rows.push_back(r);
endtask

task automatic reg_row(input logic [31:0] inst, input logic [31:0] pc, input logic [4:0] rd,
	input logic [31:0] data);
	add_row(inst, pc, rd, data, PORT_NONE, 32'h0, 32'h0);
endtask

task automatic quiet_row(input logic [31:0] inst, input logic [31:0] pc);
	add_row(inst, pc, 5'd0, 32'h0, PORT_NONE, 32'h0, 32'h0);
endtask

task automatic load_program();
	reg_row(i_type(12'd5, 5'd0, 3'b000, 5'd1, OP_I), 32'h100, 5'd1, 32'h0000_0005);
	reg_row(i_type(12'hFFD, 5'd0, 3'b000, 5'd2, OP_I), 32'h104, 5'd2, 32'hFFFF_FFFD);
	reg_row(u_type(20'h12345, 5'd3, OP_LUI), 32'h108, 5'd3, 32'h1234_5000);
	reg_row(u_type(20'h00001, 5'd4, OP_AUIPC), 32'h10C, 5'd4, 32'h0000_110C);
	reg_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 32'h110, 5'd5, 32'h0000_0002);
	reg_row(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd6), 32'h114, 5'd6, 32'h0000_0008);
	reg_row(i_type(12'h004, 5'd1, 3'b001, 5'd7, OP_I), 32'h118, 5'd7, 32'h0000_0050);
	reg_row(i_type(12'h01C, 5'd2, 3'b101, 5'd8, OP_I), 32'h11C, 5'd8, 32'h0000_000F);
	reg_row(i_type(12'h401, 5'd2, 3'b101, 5'd9, OP_I), 32'h120, 5'd9, 32'hFFFF_FFFE);
	reg_row(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd10), 32'h124, 5'd10, 32'h0000_0001);
	reg_row(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd11), 32'h128, 5'd11, 32'h0000_0000);
	reg_row(r_type(7'h00, 5'd3, 5'd1, 3'b100, 5'd12), 32'h12C, 5'd12, 32'h1234_5005);
	reg_row(r_type(7'h00, 5'd6, 5'd1, 3'b110, 5'd13), 32'h130, 5'd13, 32'h0000_000D);
	reg_row(r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd14), 32'h134, 5'd14, 32'h1234_5000);
	reg_row(r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd15), 32'h138, 5'd15, 32'hFFFF_FFFF);
	reg_row(i_type(12'd7, 5'd1, 3'b000, 5'd0, OP_I), 32'h13C, 5'd0, 32'h0); // Write to x0

	// Store, load back, load a preloaded word, then a DMA store
	reg_row(i_type(12'd32, 5'd0, 3'b000, 5'd16, OP_I), 32'h140, 5'd16, 32'h0000_0020);
	add_row(s_type(12'd4, 5'd3, 5'd16, 3'b010, OP_S), 32'h144, 5'd0, 32'h0,
		PORT_STORE, 32'h24, 32'h1234_5000);
	add_row(i_type(12'd4, 5'd16, 3'b010, 5'd17, OP_LOAD), 32'h148, 5'd17, 32'h1234_5000,
		PORT_LOAD, 32'h24, 32'h0);
	add_row(i_type(12'hFF8, 5'd16, 3'b010, 5'd18, OP_LOAD), 32'h14C, 5'd18, 32'h0,
		PORT_LOAD_MODEL, 32'h18, 32'h0);
	add_row(s_type(12'd12, 5'd6, 5'd16, 3'b010, OP_DMA_S), 32'h150, 5'd0, 32'h0,
		PORT_DMA, 32'h2C, 32'h0000_0008);

	quiet_row(b_type(13'd8, 5'd6, 5'd1, 3'b000), 32'h154);    // beq not taken
	quiet_row(b_type(13'd8, 5'd1, 5'd1, 3'b000), 32'h158);    // beq taken
	quiet_row(b_type(13'd12, 5'd6, 5'd1, 3'b001), 32'h160);   // bne taken
	quiet_row(b_type(13'd16, 5'd1, 5'd1, 3'b001), 32'h16C);   // bne not taken
	quiet_row(b_type(13'h1FE0, 5'd1, 5'd2, 3'b100), 32'h170); // blt taken backward
	quiet_row(b_type(13'd8, 5'd2, 5'd1, 3'b100), 32'h150);    // blt not taken
	quiet_row(b_type(13'd16, 5'd2, 5'd1, 3'b110), 32'h154);   // bltu taken
	quiet_row(b_type(13'd8, 5'd1, 5'd2, 3'b110), 32'h164);    // bltu not taken
	reg_row(j_type(21'h40, 5'd19), 32'h168, 5'd19, 32'h0000_016C);
	reg_row(i_type(12'h019, 5'd19, 3'b000, 5'd20, OP_JALR), 32'h1A8, 5'd20, 32'h0000_01AC);

	reg_row(i_type(12'h340, 5'd3, 3'b001, 5'd21, OP_SYSTEM), 32'h184, 5'd21, 32'h0);
	reg_row(i_type(12'h340, 5'd1, 3'b010, 5'd22, OP_SYSTEM), 32'h188, 5'd22, 32'h1234_5000);
	reg_row(i_type(12'h340, 5'd13, 3'b011, 5'd23, OP_SYSTEM), 32'h18C, 5'd23, 32'h1234_5005);
	reg_row(i_type(12'h340, 5'd3, 3'b110, 5'd24, OP_SYSTEM), 32'h190, 5'd24, 32'h1234_5000);
	reg_row(i_type(12'h340, 5'd1, 3'b111, 5'd25, OP_SYSTEM), 32'h194, 5'd25, 32'h1234_5003);
	reg_row(i_type(12'h340, 5'd0, 3'b010, 5'd26, OP_SYSTEM), 32'h198, 5'd26, 32'h1234_5002);
	quiet_row(i_type(12'h341, 5'd19, 3'b001, 5'd0, OP_SYSTEM), 32'h19C); // mepc gets 0x16C
	quiet_row(i_type(12'h302, 5'd0, 3'b000, 5'd0, OP_SYSTEM), 32'h1A0);  // mret
	reg_row(i_type(12'h341, 5'd0, 3'b010, 5'd27, OP_SYSTEM), 32'h16C, 5'd27, 32'h0000_016C);
	reg_row(i_type(12'd4, 5'd27, 3'b000, 5'd28, OP_I), 32'h170, 5'd28, 32'h0000_0170);
	quiet_row(i_type(12'd0, 5'd0, 3'b000, 5'd0, OP_I), 32'h174);
endtask

/* bench/tb_rv_core.sv */
module tb_rv_core
	import core_pkg::*;
	import bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] RESET_PC     = 32'h0000_0100;
	localparam int          RESET_CYCLES = 8;
	localparam int          SEED         = 79551;
	localparam logic [31:0] NOP_INST     = 32'h0000_0013;

	logic        clk_i;
	logic        rst_i;
	logic [31:0] inst_i;
	logic [31:0] pc_o;
	mem_req_t    mem_req_o;
	logic [31:0] mem_rdata;
	dma_req_t    dma_req_o;
	retire_t     retire_o;

	logic [31:0] mem_model [16];
	int          cycles      = 0;
	int          cycle_limit = RESET_CYCLES + 20;

	`include "tb_program.svh"

	rv_core #(
		.RESET_PC (RESET_PC)
	) u_dut (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.inst_i      (inst_i),
		.pc_o        (pc_o),
		.mem_req_o   (mem_req_o),
		.mem_rdata_i (mem_rdata),
		.dma_req_o   (dma_req_o),
		.retire_o    (retire_o)
	);

	assign mem_rdata = mem_model[mem_req_o.addr[5:2]]; // Word index inside the 16-word model

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else
			abort_run($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_row(input row_t row);
		logic        exp_mem;
		logic [31:0] exp_data;
		exp_mem  = row.port inside {PORT_LOAD, PORT_LOAD_MODEL, PORT_STORE};
		exp_data = (row.port == PORT_LOAD_MODEL) ? mem_model[row.addr[5:2]] : row.rd_data;
		check_value("retire_o.we", 32'(retire_o.we), 32'(row.rd_we));
		if (row.rd_we) begin
			check_value("retire_o.rd", 32'(retire_o.rd), 32'(row.rd));
			check_value("retire_o.data", retire_o.data, exp_data);
			check_value("retire_o.pc", retire_o.pc, row.pc);
		end
		check_value("mem_req_o.valid", 32'(mem_req_o.valid), 32'(exp_mem));
		if (exp_mem) begin
			check_value("mem_req_o.we", 32'(mem_req_o.we), 32'(row.port == PORT_STORE));
			check_value("mem_req_o.addr", mem_req_o.addr, row.addr);
		end
		if (row.port == PORT_STORE)
			check_value("mem_req_o.wdata", mem_req_o.wdata, row.wdata);
		check_value("dma_req_o.valid", 32'(dma_req_o.valid), 32'(row.port == PORT_DMA));
		if (row.port == PORT_DMA) begin
			check_value("dma_req_o.addr", dma_req_o.addr, row.addr);
			check_value("dma_req_o.data", dma_req_o.data, row.wdata);
		end
	endtask

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		assert (cycles < cycle_limit) else
			abort_run("Timeout: the instruction table did not finish within the cycle limit");
	end

	////////////////////////////////////////
	// Table loop
	////////////////////////////////////////

	initial begin
		mem_req_t store_req;
		rst_i  = 1'b1;
		inst_i = NOP_INST;
		void'($urandom(SEED));
		for (int w = 0; w < 16; w++)
			mem_model[w] = $urandom;
		load_program();
		cycle_limit = cycle_limit + rows.size();
		repeat (RESET_CYCLES) @(negedge clk_i);
		rst_i = 1'b0;

		// The first row goes out on the same falling edge that releases reset
		for (int i = 0; i < rows.size(); i++) begin
			if (i > 0)
				@(negedge clk_i);
			check_value("pc_o", pc_o, rows[i].pc);
			inst_i = rows[i].inst;
			#2;
			check_row(rows[i]);
			if (mem_req_o.valid && mem_req_o.we) begin
				store_req = mem_req_o;
				@(posedge clk_i);
				mem_model[store_req.addr[5:2]] = store_req.wdata;
			end
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

/* hw/rv_core.sv */
module rv_core
	import core_pkg::*;
	import bus_pkg::*;
#(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [31:0] inst_i,
	output logic [31:0] pc_o,
	output mem_req_t    mem_req_o,
	input  logic [31:0] mem_rdata_i,
	output dma_req_t    dma_req_o,
	output retire_t     retire_o
);

	ctrl_t       ctrl;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:0] alu_res;
	logic        take;
	logic [31:0] target;
	logic [31:0] csr_rdata;
	logic [31:0] mepc;
	logic        rd_we;
	logic [31:0] rd_data;

	ctrl_unit u_ctrl (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	reg_file u_regs (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.rs1_i      (inst_i[19:15]),
		.rs2_i      (inst_i[24:20]),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.we_i       (rd_we),
		.rd_i       (retire_o.rd),
		.wdata_i    (rd_data)
	);

	exec_unit u_exec (
		.inst_i     (inst_i),
		.ctrl_i     (ctrl),
		.pc_i       (pc_o),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.alu_res_o  (alu_res),
		.take_o     (take),
		.target_o   (target)
	);

	csr_unit u_csr (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.inst_i      (inst_i),
		.ctrl_i      (ctrl),
		.rs1_data_i  (rs1_data),
		.csr_rdata_o (csr_rdata),
		.mepc_o      (mepc)
	);

	commit_unit #(
		.RESET_PC (RESET_PC)
	) u_commit (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.inst_i      (inst_i),
		.ctrl_i      (ctrl),
		.alu_res_i   (alu_res),
		.mem_rdata_i (mem_rdata_i),
		.csr_rdata_i (csr_rdata),
		.mepc_i      (mepc),
		.target_i    (target),
		.take_i      (take),
		.pc_o        (pc_o),
		.rd_we_o     (rd_we),
		.rd_data_o   (rd_data),
		.retire_o    (retire_o)
	);

	////////////////////////////////////////
	// Data side requests
	////////////////////////////////////////

	// Address is rs1 plus offset from the ALU, data is rs2
	assign mem_req_o = '{valid: ctrl.mem_valid & ~rst_i, we: ctrl.mem_we, addr: alu_res,
		wdata: rs2_data};
	assign dma_req_o = '{valid: ctrl.dma_valid & ~rst_i, addr: alu_res, data: rs2_data};

endmodule

/* hw/commit_unit.sv */
module commit_unit
	import core_pkg::*;
	import bus_pkg::*;
#(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [31:0] inst_i,
	input  ctrl_t       ctrl_i,
	input  logic [31:0] alu_res_i,
	input  logic [31:0] mem_rdata_i,
	input  logic [31:0] csr_rdata_i,
	input  logic [31:0] mepc_i,
	input  logic [31:0] target_i,
	input  logic        take_i,
	output logic [31:0] pc_o,
	output logic        rd_we_o,
	output logic [31:0] rd_data_o,
	output retire_t     retire_o
);

	logic [31:0] pc_q;
	logic [31:0] pc_plus4;
	logic [31:0] pc_next;

	assign pc_plus4 = pc_q + 32'd4;

	always_comb begin
		case (ctrl_i.wb_sel)
			WB_MEM:  rd_data_o = mem_rdata_i;
			WB_PC4:  rd_data_o = pc_plus4;
			WB_CSR:  rd_data_o = csr_rdata_i;
			default: rd_data_o = alu_res_i;
		endcase
	end

	assign pc_next = ctrl_i.is_mret ? mepc_i : (take_i ? target_i : pc_plus4);

	always_ff @(posedge clk_i) begin
		if (rst_i)
			pc_q <= RESET_PC;
		else
			pc_q <= pc_next;
	end

	assign pc_o    = pc_q;
	assign rd_we_o = ctrl_i.reg_we;

	assign retire_o = '{we: ctrl_i.reg_we & ~rst_i, rd: inst_i[11:7], data: rd_data_o,
		pc: pc_q};

	// jalr clears only bit 0 so a bad register or mepc value shows up here
	a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
		pc_q[1:0] == 2'b00);

endmodule

/* hw/csr_unit.sv */
module csr_unit
	import core_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [31:0] inst_i,
	input  ctrl_t       ctrl_i,
	input  logic [31:0] rs1_data_i,
	output logic [31:0] csr_rdata_o,
	output logic [31:0] mepc_o
);

	logic [31:0] mscratch;
	logic [31:0] mepc;
	logic [11:0] addr;
	logic [2:0]  funct3;
	logic [31:0] src;
	logic [31:0] new_val;

	assign addr   = inst_i[31:20];
	assign funct3 = inst_i[14:12];
	assign src    = funct3[2] ? {27'd0, inst_i[19:15]} : rs1_data_i; // zimm forms

	always_comb begin
		case (addr)
			12'h340: csr_rdata_o = mscratch;
			12'h341: csr_rdata_o = mepc;
			default: csr_rdata_o = 32'd0;
		endcase
	end

	// A zero source makes set and clear rewrite the old value
	always_comb begin
		case (funct3[1:0])
			2'b10:   new_val = csr_rdata_o | src;
			2'b11:   new_val = csr_rdata_o & ~src;
			default: new_val = src;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mscratch <= '0;
			mepc     <= '0;
		end else if (ctrl_i.csr_en) begin
			if (addr == 12'h340)
				mscratch <= new_val;
			if (addr == 12'h341)
				mepc <= new_val;
		end
	end

	assign mepc_o = mepc;

endmodule

/* hw/exec_unit.sv */
module exec_unit
	import core_pkg::*;
(
	input  logic [31:0] inst_i,
	input  ctrl_t       ctrl_i,
	input  logic [31:0] pc_i,
	input  logic [31:0] rs1_data_i,
	input  logic [31:0] rs2_data_i,
	output logic [31:0] alu_res_o,
	output logic        take_o,
	output logic [31:0] target_o
);

	logic [31:0] imm;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [2:0]  funct3;
	logic        eq;
	logic        lt;
	logic        cond;

	assign funct3 = inst_i[14:12];

	always_comb begin
		case (ctrl_i.imm_sel)
			IMM_I:   imm = {{20{inst_i[31]}}, inst_i[31:20]};
			IMM_S:   imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
			IMM_B:   imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
				inst_i[11:8], 1'b0};
			IMM_J:   imm = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
				inst_i[30:21], 1'b0};
			IMM_U:   imm = {inst_i[31:12], 12'd0};
			default: imm = 32'd0;
		endcase
	end

	assign op_a = ctrl_i.a_sel_pc ? pc_i : rs1_data_i;
	assign op_b = ctrl_i.b_sel_imm ? imm : rs2_data_i;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	always_comb begin
		case (ctrl_i.alu_op)
			ALU_ADD:    alu_res_o = op_a + op_b;
			ALU_SUB:    alu_res_o = op_a - op_b;
			ALU_SLL:    alu_res_o = op_a << op_b[4:0];
			ALU_SLT:    alu_res_o = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_res_o = {31'd0, op_a < op_b};
			ALU_XOR:    alu_res_o = op_a ^ op_b;
			ALU_SRL:    alu_res_o = op_a >> op_b[4:0];
			ALU_SRA:    alu_res_o = $unsigned($signed(op_a) >>> op_b[4:0]);
			ALU_OR:     alu_res_o = op_a | op_b;
			ALU_AND:    alu_res_o = op_a & op_b;
			ALU_PASS_B: alu_res_o = op_b;
			default:    alu_res_o = op_a + op_b;
		endcase
	end

	////////////////////////////////////////
	// Branch decision
	////////////////////////////////////////

	assign eq = (rs1_data_i == rs2_data_i);
	assign lt = ctrl_i.br_unsigned ? (rs1_data_i < rs2_data_i)
		: ($signed(rs1_data_i) < $signed(rs2_data_i));

	// funct3[2] picks the less-than test and funct3[0] inverts it
	assign cond = (funct3[2] ? lt : eq) ^ funct3[0];

	assign take_o = ctrl_i.jump | (ctrl_i.branch & cond);

	// Branches and jal sum pc and immediate in the ALU, jalr sums rs1
	assign target_o = {alu_res_o[31:1], alu_res_o[0] & ~ctrl_i.jump_reg};

endmodule

/* hw/reg_file.sv */
module reg_file (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [4:0]  rs1_i,
	input  logic [4:0]  rs2_i,
	output logic [31:0] rs1_data_o,
	output logic [31:0] rs2_data_o,
	input  logic        we_i,
	input  logic [4:0]  rd_i,
	input  logic [31:0] wdata_i
);

	logic [31:0] regs [32];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we_i && rd_i != 5'd0) begin
			regs[rd_i] <= wdata_i;
		end
	end

	// x0 stays at its reset value since writes never reach it
	assign rs1_data_o = regs[rs1_i];
	assign rs2_data_o = regs[rs2_i];

	a_x0_zero: assert property (@(posedge clk_i) disable iff (rst_i)
		(rs1_i == 5'd0) |-> (rs1_data_o == 32'd0));

endmodule

/* hw/ctrl_unit.sv */
module ctrl_unit
	import core_pkg::*;
(
	input  logic [31:0] inst_i,
	output ctrl_t       ctrl_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [4:0] rd;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign rd     = inst_i[11:7];

	always_comb begin
		ctrl_o         = '0;
		ctrl_o.alu_op  = ALU_ADD;  // Address and pc-relative sums
		ctrl_o.imm_sel = IMM_NONE;
		ctrl_o.wb_sel  = WB_ALU;
		case (opcode)
			OP_R: begin
				ctrl_o.reg_we = 1'b1;
				ctrl_o.alu_op = alu_op_e'({inst_i[30], funct3});
			end
			OP_I: begin
				ctrl_o.reg_we    = 1'b1;
				ctrl_o.b_sel_imm = 1'b1;
				ctrl_o.imm_sel   = IMM_I;
				// Bit 30 only selects srai, otherwise it is immediate data
				ctrl_o.alu_op    = alu_op_e'({(funct3 == 3'b101) & inst_i[30], funct3});
			end
			OP_LOAD: begin
				ctrl_o.reg_we    = 1'b1;
				ctrl_o.b_sel_imm = 1'b1;
				ctrl_o.imm_sel   = IMM_I;
				ctrl_o.wb_sel    = WB_MEM;
				ctrl_o.mem_valid = 1'b1;
			end
			OP_S: begin
				ctrl_o.b_sel_imm = 1'b1;
				ctrl_o.imm_sel   = IMM_S;
				ctrl_o.mem_valid = 1'b1;
				ctrl_o.mem_we    = 1'b1;
			end
			OP_DMA_S: begin
				ctrl_o.b_sel_imm = 1'b1;
				ctrl_o.imm_sel   = IMM_S;
				ctrl_o.dma_valid = 1'b1;
			end
			OP_B: begin
				ctrl_o.a_sel_pc    = 1'b1;
				ctrl_o.b_sel_imm   = 1'b1;
				ctrl_o.imm_sel     = IMM_B;
				ctrl_o.branch      = 1'b1;
				ctrl_o.br_unsigned = (funct3[2:1] == 2'b11); // bltu, bgeu
			end
			OP_JAL: begin
				ctrl_o.reg_we    = 1'b1;
				ctrl_o.a_sel_pc  = 1'b1;
				ctrl_o.b_sel_imm = 1'b1;
				ctrl_o.imm_sel   = IMM_J;
				ctrl_o.wb_sel    = WB_PC4;
				ctrl_o.jump      = 1'b1;
			end
			OP_JALR: begin
				ctrl_o.reg_we    = 1'b1;
				ctrl_o.b_sel_imm = 1'b1;
				ctrl_o.imm_sel   = IMM_I;
				ctrl_o.wb_sel    = WB_PC4;
				ctrl_o.jump      = 1'b1;
				ctrl_o.jump_reg  = 1'b1;
			end
			OP_LUI: begin
				ctrl_o.reg_we    = 1'b1;
				ctrl_o.b_sel_imm = 1'b1;
				ctrl_o.imm_sel   = IMM_U;
				ctrl_o.alu_op    = ALU_PASS_B;
			end
			OP_AUIPC: begin
				ctrl_o.reg_we    = 1'b1;
				ctrl_o.a_sel_pc  = 1'b1;
				ctrl_o.b_sel_imm = 1'b1;
				ctrl_o.imm_sel   = IMM_U;
			end
			OP_SYSTEM: begin
				if (funct3 == 3'b000 && inst_i[31:20] == 12'h302) begin
					ctrl_o.is_mret = 1'b1;
				end else if (funct3[1:0] != 2'b00) begin
					ctrl_o.csr_en = 1'b1;
					ctrl_o.reg_we = 1'b1;
					ctrl_o.wb_sel = WB_CSR;
				end
			end
			default: ;
		endcase
		if (rd == 5'd0)
			ctrl_o.reg_we = 1'b0;
	end

	always_comb begin
		assert (!(ctrl_o.mem_valid && ctrl_o.dma_valid)); // One data port per instruction
		if (!(opcode inside {OP_R, OP_I, OP_LOAD, OP_S, OP_B, OP_JAL, OP_JALR,
			OP_LUI, OP_AUIPC, OP_SYSTEM, OP_DMA_S}))
			assert (!ctrl_o.reg_we && !ctrl_o.mem_valid && !ctrl_o.dma_valid
				&& !ctrl_o.csr_en);
	end

endmodule

/* hw/bus_pkg.sv */
package bus_pkg;

	// Word access toward the data cache
	typedef struct packed {
		logic        valid;
		logic        we;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] data;
	} dma_req_t;

	// One record per retired instruction
	typedef struct packed {
		logic        we;
		logic [4:0]  rd;
		logic [31:0] data;
		logic [31:0] pc;
	} retire_t;

endpackage

/* hw/core_pkg.sv */
package core_pkg;

	////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////

	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_I      = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_S      = 7'b0100011,
		OP_B      = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_SYSTEM = 7'b1110011,
		OP_DMA_S  = 7'b0001011 // Custom-0 slot used by the store toward the DMA port
	} opcode_e;

	// Arithmetic codes line up with {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SLL    = 4'b0001,
		ALU_SLT    = 4'b0010,
		ALU_SLTU   = 4'b0011,
		ALU_XOR    = 4'b0100,
		ALU_SRL    = 4'b0101,
		ALU_OR     = 4'b0110,
		ALU_AND    = 4'b0111,
		ALU_SUB    = 4'b1000,
		ALU_SRA    = 4'b1101,
		ALU_PASS_B = 4'b1111 // lui
	} alu_op_e;

	typedef enum logic [2:0] {
		IMM_I    = 3'd0,
		IMM_S    = 3'd1,
		IMM_B    = 3'd2,
		IMM_J    = 3'd3,
		IMM_U    = 3'd4,
		IMM_NONE = 3'd7
	} imm_sel_e;

	typedef enum logic [1:0] {
		WB_MEM = 2'd0,
		WB_ALU = 2'd1,
		WB_PC4 = 2'd2,
		WB_CSR = 2'd3
	} wb_sel_e;

	////////////////////////////////////////
	// Decoded controls
	////////////////////////////////////////

	typedef struct packed {
		logic     reg_we;
		alu_op_e  alu_op;
		logic     a_sel_pc;   // Operand A is pc instead of rs1
		logic     b_sel_imm;  // Operand B is the immediate instead of rs2
		imm_sel_e imm_sel;
		wb_sel_e  wb_sel;
		logic     mem_valid;
		logic     mem_we;
		logic     dma_valid;
		logic     branch;
		logic     br_unsigned;
		logic     jump;
		logic     jump_reg;
		logic     csr_en;
		logic     is_mret;
	} ctrl_t;

endpackage
